//--- design/ecc_bank_if.sv
`timescale 1ns/10ps
`default_nettype none

// One bank access per cycle with req high, read data follows one cycle later
interface ecc_bank_if
  import ecc_pkg::*;
#(
  parameter int unsigned BankWords = 16
) ();

  localparam int unsigned AddrWidth = $clog2(BankWords);

  logic                 req;
  logic                 we;
  // Marks scrubber traffic, both the scrub reads and the writebacks
  logic                 is_scrub;
  logic [AddrWidth-1:0] addr;
  ecc_codeword_u        wdata;
  ecc_codeword_u        rdata;

  modport port (output req, output we, output is_scrub, output addr, output wdata);

  modport bank (input req, input we, input is_scrub, input addr, input wdata, output rdata);

  // The checker only watches the traffic and the returned codeword
  modport check (input req, input we, input is_scrub, input addr, input rdata);

endinterface

`default_nettype wire

//--- design/ecc_bank_port.sv
`timescale 1ns/10ps
`default_nettype none

module ecc_bank_port
  import ecc_pkg::*;
#(
  parameter  int unsigned BankWords = 16,
  localparam int unsigned AddrWidth = $clog2(BankWords)
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 mem_req_i,
  input  logic                 mem_we_i,
  input  logic [AddrWidth-1:0] mem_addr_i,
  input  logic [DataWidth-1:0] mem_wdata_i,
  input  logic                 scrub_trigger_i,
  input  logic [DataWidth-1:0] mask_data_n_i,
  input  logic [EccWidth-1:0]  mask_ecc_n_i,
  input  logic                 fix_req_i,
  input  logic [AddrWidth-1:0] fix_addr_i,
  input  ecc_codeword_u        fix_word_i,
  ecc_bank_if.port             bank_o
);

  logic                 scrub_pend_q;
  logic                 scrub_rd_q;
  logic [AddrWidth-1:0] scrub_addr_q;
  logic                 scrub_want;
  logic                 fix_go;
  logic                 scrub_go;
  ecc_codeword_u        user_word;

  // Encode the user word, then flip every bit whose mask bit is low
  always_comb begin
    user_word     = ecc_encode(mem_wdata_i);
    user_word.raw = user_word.raw ^ ~{mask_ecc_n_i, mask_data_n_i};
  end

  // A trigger may issue in its own cycle when the bank is idle
  assign scrub_want = scrub_pend_q || scrub_trigger_i;

  // User first, then a pending writeback, then the scrub read
  assign fix_go = !mem_req_i && fix_req_i;

  // Only one scrub read may wait for its check result at a time
  assign scrub_go = !mem_req_i && !fix_req_i && !scrub_rd_q && scrub_want;

  always_comb begin
    bank_o.req      = mem_req_i || fix_go || scrub_go;
    bank_o.we       = mem_req_i ? mem_we_i : fix_go;
    bank_o.is_scrub = !mem_req_i;
    if (mem_req_i) begin
      bank_o.addr = mem_addr_i;
    end else if (fix_go) begin
      bank_o.addr = fix_addr_i;
    end else begin
      bank_o.addr = scrub_addr_q;
    end
    // Writebacks carry the corrected codeword straight through
    bank_o.wdata = mem_req_i ? user_word : fix_word_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      scrub_pend_q <= 1'b0;
      scrub_rd_q   <= 1'b0;
      scrub_addr_q <= '0;
    end else begin
      // Triggers seen while a scrub is still waiting fold into the same request
      scrub_pend_q <= scrub_want && !scrub_go;
      scrub_rd_q   <= scrub_go;
      // The pointer wraps by itself since the depth is a power of two
      if (scrub_go) begin
        scrub_addr_q <= scrub_addr_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/ecc_manager.sv
`timescale 1ns/10ps
`default_nettype none

module ecc_manager
  import ecc_pkg::*;
  import ecc_reg_pkg::*;
#(
  parameter int unsigned NumBanks = 2
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               reg_valid_i,
  input  logic                               reg_write_i,
  input  logic [RegAddrWidth-1:0]            reg_addr_i,
  input  logic [RegDataWidth-1:0]            reg_wdata_i,
  output logic [RegDataWidth-1:0]            reg_rdata_o,
  output logic                               reg_error_o,
  input  logic [NumBanks-1:0]                access_fault_i,
  input  logic [NumBanks-1:0]                scrub_fix_i,
  output logic [NumBanks-1:0]                scrub_trigger_o,
  output logic [NumBanks-1:0][DataWidth-1:0] mask_data_n_o,
  output logic [NumBanks-1:0][EccWidth-1:0]  mask_ecc_n_o
);

  // Kind 0 counts mismatches and kind 1 counts scrub fixes, in field order
  localparam int unsigned NumKinds = 2;

  logic [FieldWidth-1:0]                               field;
  logic [BankIdxWidth-1:0]                             bank_idx;
  logic [NumBanks-1:0]                                 bank_sel;
  logic                                                bank_ok;
  logic                                                field_ok;
  logic                                                wr_en;
  logic [NumKinds-1:0][NumBanks-1:0]                   inc;
  logic [RegDataWidth-1:0]                             interval_q;
  logic [NumBanks-1:0][NumKinds-1:0][RegDataWidth-1:0] count_q;
  logic [NumBanks-1:0][RegDataWidth-1:0]               tick_q;

  assign field    = reg_addr_i[RegAddrWidth-1 -: FieldWidth];
  assign bank_idx = reg_addr_i[BankIdxWidth-1:0];
  assign inc      = {scrub_fix_i, access_fault_i};
  // Rejected accesses never change a register
  assign wr_en    = reg_valid_i && reg_write_i && !reg_error_o;

  // Register read path, purely combinational
  always_comb begin
    reg_rdata_o = '0;
    bank_sel    = '0;
    for (int unsigned b = 0; b < NumBanks; b++) begin
      bank_sel[b] = (bank_idx == BankIdxWidth'(b));
      if (bank_sel[b]) begin
        case (field)
          FieldMismatchCount: reg_rdata_o = count_q[b][0];
          FieldScrubFixCount: reg_rdata_o = count_q[b][1];
          FieldMaskDataN:     reg_rdata_o = mask_data_n_o[b];
          FieldMaskEccN:      reg_rdata_o = RegDataWidth'(mask_ecc_n_o[b]);
          default:            reg_rdata_o = '0;
        endcase
      end
    end
    // Field indices are contiguous from the interval up to the ecc mask
    field_ok = (field <= FieldMaskEccN);
    bank_ok  = |bank_sel;
    if (field == FieldScrubInterval) begin
      reg_rdata_o = interval_q;
      bank_ok     = (bank_idx == '0);
    end
    reg_error_o = reg_valid_i && !(field_ok && bank_ok);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      interval_q    <= '0;
      count_q       <= '0;
      mask_data_n_o <= '1;
      mask_ecc_n_o  <= '1;
    end else begin
      if (wr_en && field == FieldScrubInterval) begin
        interval_q <= reg_wdata_i;
      end
      for (int unsigned b = 0; b < NumBanks; b++) begin
        // Software writes take priority over a same-cycle increment
        for (int unsigned k = 0; k < NumKinds; k++) begin
          if (wr_en && bank_sel[b] && field == FieldMismatchCount + FieldWidth'(k)) begin
            count_q[b][k] <= reg_wdata_i;
          end else if (inc[k][b]) begin
            count_q[b][k] <= count_q[b][k] + 1'b1;
          end
        end
        if (wr_en && bank_sel[b] && field == FieldMaskDataN) begin
          mask_data_n_o[b] <= reg_wdata_i;
        end
        if (wr_en && bank_sel[b] && field == FieldMaskEccN) begin
          mask_ecc_n_o[b] <= reg_wdata_i[EccWidth-1:0];
        end
      end
    end
  end

  // Interval counters run 0 to I and wrap, a zero interval holds them clear
  always_ff @(posedge clk_i) begin
    for (int unsigned b = 0; b < NumBanks; b++) begin
      if (!rst_n_i || interval_q == '0 || tick_q[b] == interval_q) begin
        tick_q[b] <= '0;
      end else begin
        tick_q[b] <= tick_q[b] + 1'b1;
      end
    end
  end

  // One trigger pulse every I+1 cycles, at the wrap point
  always_comb begin
    for (int unsigned b = 0; b < NumBanks; b++) begin
      scrub_trigger_o[b] = (interval_q != '0) && (tick_q[b] == interval_q);
    end
  end

endmodule

`default_nettype wire

//--- design/ecc_pkg.sv
`default_nettype none

package ecc_pkg;

  localparam int unsigned DataWidth = 32;
  localparam int unsigned EccWidth  = 7;
  localparam int unsigned CodeWidth = DataWidth + EccWidth;
  // Hamming syndrome bits, the top check bit holds the overall parity
  localparam int unsigned SynWidth  = EccWidth - 1;

  typedef struct packed {
    logic [EccWidth-1:0]  ecc;
    logic [DataWidth-1:0] data;
  } ecc_fields_t;

  // The raw view feeds parity and the test masks, the field view feeds the codec
  typedef union packed {
    logic [CodeWidth-1:0] raw;
    ecc_fields_t          f;
  } ecc_codeword_u;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic                 single_err;
    logic                 double_err;
  } ecc_decode_t;

  // Data bits sit on the Hamming positions that are not a power of two, from 3 upward
  // The syndrome part is the XOR of the positions of all set data bits
  function automatic logic [SynWidth-1:0] ecc_syndrome(input logic [DataWidth-1:0] data);
    logic [SynWidth-1:0] syn;
    int unsigned         j;
    syn = '0;
    j   = 0;
    for (int unsigned p = 3; p < CodeWidth; p++) begin
      if ((p & (p - 1)) != 0) begin
        if (data[j]) begin
          syn ^= SynWidth'(p);
        end
        j++;
      end
    end
    return syn;
  endfunction

  function automatic ecc_codeword_u ecc_encode(input logic [DataWidth-1:0] data);
    ecc_codeword_u cw;
    cw.f.data            = data;
    cw.f.ecc[SynWidth-1:0] = ecc_syndrome(data);
    // Overall parity makes the XOR of the whole codeword zero
    cw.f.ecc[EccWidth-1] = ^{cw.f.ecc[SynWidth-1:0], data};
    return cw;
  endfunction

  function automatic ecc_decode_t ecc_decode(input ecc_codeword_u cw);
    ecc_decode_t         res;
    logic [SynWidth-1:0] syn;
    logic                par;
    int unsigned         j;
    syn            = cw.f.ecc[SynWidth-1:0] ^ ecc_syndrome(cw.f.data);
    par            = ^cw.raw;
    res.data       = cw.f.data;
    // Odd parity means one flip, even parity with a syndrome means two
    res.single_err = par;
    res.double_err = !par && (syn != '0);
    j              = 0;
    // A syndrome that points at a check bit leaves the data as it is
    for (int unsigned p = 3; p < CodeWidth; p++) begin
      if ((p & (p - 1)) != 0) begin
        if (par && syn == SynWidth'(p)) begin
          res.data[j] = ~res.data[j];
        end
        j++;
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

//--- design/ecc_read_check.sv
`timescale 1ns/10ps
`default_nettype none

module ecc_read_check
  import ecc_pkg::*;
#(
  parameter  int unsigned BankWords = 16,
  localparam int unsigned AddrWidth = $clog2(BankWords)
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  ecc_bank_if.check            bank_i,
  output logic                 mem_rvalid_o,
  output logic [DataWidth-1:0] mem_rdata_o,
  output logic                 mem_fault_o,
  output logic                 mem_uncorr_o,
  output logic                 access_fault_o,
  output logic                 scrub_fix_o,
  output logic                 fix_req_o,
  output logic [AddrWidth-1:0] fix_addr_o,
  output ecc_codeword_u        fix_word_o
);

  logic                 user_rd_q;
  logic                 scrub_rd_q;
  logic [AddrWidth-1:0] rd_addr_q;
  ecc_decode_t          dec;
  logic                 user_wr;
  logic                 fix_hit;
  logic                 fix_drop;

  // rdata belongs to the read that was issued one cycle earlier
  assign dec     = ecc_decode(bank_i.rdata);
  assign user_wr = bank_i.req && bank_i.we && !bank_i.is_scrub;

  // A word the user overwrites in this same cycle must not be written back
  assign fix_hit = scrub_rd_q && dec.single_err && !(user_wr && bank_i.addr == rd_addr_q);

  // The writeback retires once the port issues it, or when the user writes that word first
  assign fix_drop = bank_i.req && bank_i.we && (bank_i.is_scrub || bank_i.addr == fix_addr_o);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      user_rd_q    <= 1'b0;
      scrub_rd_q   <= 1'b0;
      mem_rvalid_o <= 1'b0;
      mem_fault_o  <= 1'b0;
      mem_uncorr_o <= 1'b0;
      scrub_fix_o  <= 1'b0;
      fix_req_o    <= 1'b0;
    end else begin
      user_rd_q    <= bank_i.req && !bank_i.we && !bank_i.is_scrub;
      scrub_rd_q   <= bank_i.req && !bank_i.we && bank_i.is_scrub;
      mem_rvalid_o <= user_rd_q;
      mem_fault_o  <= user_rd_q && dec.single_err;
      mem_uncorr_o <= user_rd_q && dec.double_err;
      // Double errors on scrub reads cannot be repaired and are skipped
      scrub_fix_o  <= fix_hit;
      if (fix_hit) begin
        fix_req_o <= 1'b1;
      end else if (fix_drop) begin
        fix_req_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rd_addr_q <= bank_i.addr;
    if (user_rd_q) begin
      mem_rdata_o <= dec.data;
    end
    // Re-encoding gives a clean codeword, also when the flip was in a check bit
    if (fix_hit) begin
      fix_addr_o <= rd_addr_q;
      fix_word_o <= ecc_encode(dec.data);
    end
  end

  // The manager counts the same corrected user reads that the user sees flagged
  assign access_fault_o = mem_fault_o;

endmodule

`default_nettype wire

//--- design/ecc_reg_pkg.sv
`default_nettype none

package ecc_reg_pkg;

  localparam int unsigned MaxBanks     = 8;
  localparam int unsigned RegDataWidth = 32;

  // Register address is the field index on top of the bank index
  localparam int unsigned RegAddrWidth = 6;
  localparam int unsigned BankIdxWidth = $clog2(MaxBanks);
  localparam int unsigned FieldWidth   = RegAddrWidth - BankIdxWidth;

  // Shared by all banks, only bank index 0 is decoded
  localparam logic [FieldWidth-1:0] FieldScrubInterval = FieldWidth'(0);
  // Corrected errors seen on user reads
  localparam logic [FieldWidth-1:0] FieldMismatchCount = FieldWidth'(1);
  // Corrected errors written back by the scrubber
  localparam logic [FieldWidth-1:0] FieldScrubFixCount = FieldWidth'(2);
  // Active low test masks, a zero bit flips that bit on user writes
  localparam logic [FieldWidth-1:0] FieldMaskDataN     = FieldWidth'(3);
  localparam logic [FieldWidth-1:0] FieldMaskEccN      = FieldWidth'(4);

endpackage

`default_nettype wire

//--- design/ecc_sram_bank.sv
`timescale 1ns/10ps
`default_nettype none

module ecc_sram_bank
  import ecc_pkg::*;
#(
  parameter int unsigned BankWords = 16
) (
  input  logic     clk_i,
  ecc_bank_if.bank bank_i
);

  ecc_codeword_u mem_q [BankWords];

  // Single port: a cycle either writes the word or reads it into rdata
  always_ff @(posedge clk_i) begin
    if (bank_i.req) begin
      if (bank_i.we) begin
        mem_q[bank_i.addr] <= bank_i.wdata;
      end else begin
        // rdata holds its value until the next read
        bank_i.rdata <= mem_q[bank_i.addr];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/ecc_sram_top.sv
`timescale 1ns/10ps
`default_nettype none

module ecc_sram_top
  import ecc_pkg::*;
  import ecc_reg_pkg::*;
#(
  parameter  int unsigned NumBanks  = 2,
  parameter  int unsigned BankWords = 16,
  localparam int unsigned AddrWidth = $clog2(BankWords)
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               reg_valid_i,
  input  logic                               reg_write_i,
  input  logic [RegAddrWidth-1:0]            reg_addr_i,
  input  logic [RegDataWidth-1:0]            reg_wdata_i,
  output logic [RegDataWidth-1:0]            reg_rdata_o,
  output logic                               reg_error_o,
  input  logic [NumBanks-1:0]                mem_req_i,
  input  logic [NumBanks-1:0]                mem_we_i,
  input  logic [NumBanks-1:0][AddrWidth-1:0] mem_addr_i,
  input  logic [NumBanks-1:0][DataWidth-1:0] mem_wdata_i,
  output logic [NumBanks-1:0]                mem_rvalid_o,
  output logic [NumBanks-1:0][DataWidth-1:0] mem_rdata_o,
  output logic [NumBanks-1:0]                mem_fault_o,
  output logic [NumBanks-1:0]                mem_uncorr_o
);

  logic [NumBanks-1:0]                scrub_trigger;
  logic [NumBanks-1:0][DataWidth-1:0] mask_data_n;
  logic [NumBanks-1:0][EccWidth-1:0]  mask_ecc_n;
  logic [NumBanks-1:0]                access_fault;
  logic [NumBanks-1:0]                scrub_fix;
  // Writeback requests from each checker back to its port
  logic [NumBanks-1:0]                fix_req;
  logic [NumBanks-1:0][AddrWidth-1:0] fix_addr;
  ecc_codeword_u [NumBanks-1:0]       fix_word;

  ecc_manager #(
    .NumBanks (NumBanks)
  ) i_manager (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .reg_valid_i     (reg_valid_i),
    .reg_write_i     (reg_write_i),
    .reg_addr_i      (reg_addr_i),
    .reg_wdata_i     (reg_wdata_i),
    .reg_rdata_o     (reg_rdata_o),
    .reg_error_o     (reg_error_o),
    .access_fault_i  (access_fault),
    .scrub_fix_i     (scrub_fix),
    .scrub_trigger_o (scrub_trigger),
    .mask_data_n_o   (mask_data_n),
    .mask_ecc_n_o    (mask_ecc_n)
  );

  // Each bank is a port, the memory and its read checker around one bus
  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    ecc_bank_if #(
      .BankWords (BankWords)
    ) bank_bus ();

    ecc_bank_port #(
      .BankWords (BankWords)
    ) i_port (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .mem_req_i       (mem_req_i[b]),
      .mem_we_i        (mem_we_i[b]),
      .mem_addr_i      (mem_addr_i[b]),
      .mem_wdata_i     (mem_wdata_i[b]),
      .scrub_trigger_i (scrub_trigger[b]),
      .mask_data_n_i   (mask_data_n[b]),
      .mask_ecc_n_i    (mask_ecc_n[b]),
      .fix_req_i       (fix_req[b]),
      .fix_addr_i      (fix_addr[b]),
      .fix_word_i      (fix_word[b]),
      .bank_o          (bank_bus.port)
    );

    ecc_sram_bank #(
      .BankWords (BankWords)
    ) i_bank (
      .clk_i  (clk_i),
      .bank_i (bank_bus.bank)
    );

    ecc_read_check #(
      .BankWords (BankWords)
    ) i_check (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .bank_i         (bank_bus.check),
      .mem_rvalid_o   (mem_rvalid_o[b]),
      .mem_rdata_o    (mem_rdata_o[b]),
      .mem_fault_o    (mem_fault_o[b]),
      .mem_uncorr_o   (mem_uncorr_o[b]),
      .access_fault_o (access_fault[b]),
      .scrub_fix_o    (scrub_fix[b]),
      .fix_req_o      (fix_req[b]),
      .fix_addr_o     (fix_addr[b]),
      .fix_word_o     (fix_word[b])
    );
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the ECC SRAM testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tb_ecc_sram -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_ecc_sram)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
  exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

//--- sources.f
+incdir+testbench
design/ecc_pkg.sv
design/ecc_reg_pkg.sv
design/ecc_bank_if.sv
design/ecc_bank_port.sv
design/ecc_sram_bank.sv
design/ecc_read_check.sv
design/ecc_manager.sv
design/ecc_sram_top.sv
testbench/tb_ecc_sram.sv

//--- testbench/tb_ecc_sram_tasks.svh
`ifndef TB_ECC_SRAM_TASKS_SVH
`define TB_ECC_SRAM_TASKS_SVH

// Register address is the field index on top of the bank index
function automatic logic [RegAddrWidth-1:0] reg_addr(input int unsigned field,
                                                     input int unsigned bank);
  return {3'(field), 3'(bank)};
endfunction

// Takes effect at the next rising edge
task automatic reg_write(input int unsigned field, input int unsigned bank,
                         input logic [31:0] data);
  reg_valid_i = 1'b1;
  reg_write_i = 1'b1;
  reg_addr_i  = reg_addr(field, bank);
  reg_wdata_i = data;
  #1;
  check_val("reg_error_o", 32'(reg_error_o), 32'h0);
  @(posedge clk_i);
  #2;
  reg_valid_i = 1'b0;
  reg_write_i = 1'b0;
endtask

// The read path is combinational, so the data is sampled within the same cycle
task automatic reg_read(input int unsigned field, input int unsigned bank,
                        output logic [31:0] data);
  reg_valid_i = 1'b1;
  reg_write_i = 1'b0;
  reg_addr_i  = reg_addr(field, bank);
  #1;
  check_val("reg_error_o", 32'(reg_error_o), 32'h0);
  data = reg_rdata_o;
  @(posedge clk_i);
  #2;
  reg_valid_i = 1'b0;
endtask

task automatic reg_expect(input int unsigned field, input int unsigned bank,
                          input logic [31:0] exp);
  logic [31:0] got;
  reg_read(field, bank, got);
  check_val($sformatf("reg_rdata_o field %0d bank %0d", field, bank), got, exp);
endtask

task automatic reg_expect_error(input int unsigned field, input int unsigned bank);
  reg_valid_i = 1'b1;
  reg_write_i = 1'b0;
  reg_addr_i  = reg_addr(field, bank);
  #1;
  check_val($sformatf("reg_error_o field %0d bank %0d", field, bank),
            32'(reg_error_o), 32'h1);
  @(posedge clk_i);
  #2;
  reg_valid_i = 1'b0;
endtask

// A user write also updates the data model of that bank
task automatic mem_write(input int unsigned bank, input int unsigned addr,
                         input logic [31:0] data);
  model[bank][addr] = data;
  mem_req_i[bank]   = 1'b1;
  mem_we_i[bank]    = 1'b1;
  mem_addr_i[bank]  = AddrWidth'(addr);
  mem_wdata_i[bank] = data;
  @(posedge clk_i);
  #2;
  mem_req_i[bank] = 1'b0;
  mem_we_i[bank]  = 1'b0;
endtask

// Issues one read and queues its expected response
// Calls in a row give back to back reads
task automatic mem_read(input int unsigned bank, input int unsigned addr,
                        input logic [31:0] data, input logic fault, input logic uncorr);
  exp_q.push_back({1'(bank), uncorr, fault, data});
  mem_req_i[bank]  = 1'b1;
  mem_we_i[bank]   = 1'b0;
  mem_addr_i[bank] = AddrWidth'(addr);
  @(posedge clk_i);
  #2;
  mem_req_i[bank] = 1'b0;
endtask

task automatic wait_reads_done();
  int unsigned cycles;
  cycles = 0;
  while (exp_q.size() != 0) begin
    @(posedge clk_i);
    #2;
    cycles++;
    if (cycles > 20) begin
      fail_now("Timeout while waiting for read responses");
    end
  end
  // The fault pulse reaches the mismatch counter one cycle after the response
  repeat (2) @(posedge clk_i);
  #2;
endtask

// Writes one word through the test masks of its bank, then restores them to all ones
task automatic write_masked(input int unsigned bank, input int unsigned addr,
                            input logic [31:0] data, input logic [31:0] data_mask_n,
                            input logic [6:0] ecc_mask_n);
  reg_write(FieldMaskDataN, bank, data_mask_n);
  reg_write(FieldMaskEccN, bank, 32'(ecc_mask_n));
  mem_write(bank, addr, data);
  reg_write(FieldMaskDataN, bank, 32'hffff_ffff);
  reg_write(FieldMaskEccN, bank, 32'h7f);
endtask

// Polls the scrub fix count for up to several full passes over the bank
task automatic wait_scrub_count(input int unsigned bank, input logic [31:0] target);
  int unsigned cycles;
  logic [31:0] cnt;
  cycles = 0;
  reg_read(FieldScrubFixCount, bank, cnt);
  while (cnt < target) begin
    cycles++;
    if (cycles > 600) begin
      fail_now("Timeout while waiting for the scrubber to repair the injected errors");
    end
    reg_read(FieldScrubFixCount, bank, cnt);
  end
  check_val("reg_rdata_o scrub fix count", cnt, target);
endtask

`endif

//--- testbench/tb_ecc_sram.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ecc_sram
  import ecc_reg_pkg::*;
();

  localparam int unsigned NumBanks  = 2;
  localparam int unsigned BankWords = 16;
  localparam int unsigned AddrWidth = $clog2(BankWords);
  localparam int unsigned Period    = 40;

  logic                               clk_i;
  logic                               rst_n_i;
  logic                               reg_valid_i;
  logic                               reg_write_i;
  logic [RegAddrWidth-1:0]            reg_addr_i;
  logic [RegDataWidth-1:0]            reg_wdata_i;
  logic [RegDataWidth-1:0]            reg_rdata_o;
  logic                               reg_error_o;
  logic [NumBanks-1:0]                mem_req_i;
  logic [NumBanks-1:0]                mem_we_i;
  logic [NumBanks-1:0][AddrWidth-1:0] mem_addr_i;
  logic [NumBanks-1:0][31:0]          mem_wdata_i;
  logic [NumBanks-1:0]                mem_rvalid_o;
  logic [NumBanks-1:0][31:0]          mem_rdata_o;
  logic [NumBanks-1:0]                mem_fault_o;
  logic [NumBanks-1:0]                mem_uncorr_o;

  // Data that each bank should hold, as written by the user
  logic [31:0]         model [NumBanks][BankWords];
  // Expected read responses in issue order, laid out as {bank, uncorr, fault, data}
  logic [34:0]         exp_q [$];
  // User reads issued one and two cycles ago
  logic [NumBanks-1:0] rd_d1;
  logic [NumBanks-1:0] rd_d2;
  integer              seed;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else fail_now($sformatf("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  initial begin
    clk_i = 1'b0;
    forever begin
      #(Period / 2) clk_i = ~clk_i;
    end
  end

  ecc_sram_top #(
    .NumBanks  (NumBanks),
    .BankWords (BankWords)
  ) UUT (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .reg_valid_i  (reg_valid_i),
    .reg_write_i  (reg_write_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_rdata_o  (reg_rdata_o),
    .reg_error_o  (reg_error_o),
    .mem_req_i    (mem_req_i),
    .mem_we_i     (mem_we_i),
    .mem_addr_i   (mem_addr_i),
    .mem_wdata_i  (mem_wdata_i),
    .mem_rvalid_o (mem_rvalid_o),
    .mem_rdata_o  (mem_rdata_o),
    .mem_fault_o  (mem_fault_o),
    .mem_uncorr_o (mem_uncorr_o)
  );

  // A user read sampled at one edge must show up two edges later, and nothing else may
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_d1 <= '0;
      rd_d2 <= '0;
    end else begin
      rd_d1 <= mem_req_i & ~mem_we_i;
      rd_d2 <= rd_d1;
    end
  end

  rvalid_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rvalid_o == rd_d2)
  else fail_now($sformatf("[FAIL] mem_rvalid_o got 0x%h expected 0x%h",
                          $sampled(mem_rvalid_o), $sampled(rd_d2)));

  // The error flags belong to a read response
  flags_with_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ((mem_fault_o | mem_uncorr_o) & ~mem_rvalid_o) == '0)
  else fail_now("A fault or uncorrectable flag was raised without a read response");

  // Responses are compared in the middle of the cycle, where outputs are stable
  always @(negedge clk_i) begin : check_responses
    logic [34:0] exp_word;
    for (int b = 0; b < NumBanks; b++) begin
      if (rst_n_i && mem_rvalid_o[b]) begin
        if (exp_q.size() == 0) begin
          fail_now("A read response arrived with no read outstanding");
        end
        exp_word = exp_q.pop_front();
        check_val("response bank", 32'(b), 32'(exp_word[34]));
        check_val("mem_rdata_o", mem_rdata_o[b], exp_word[31:0]);
        check_val("mem_fault_o", 32'(mem_fault_o[b]), 32'(exp_word[32]));
        check_val("mem_uncorr_o", 32'(mem_uncorr_o[b]), 32'(exp_word[33]));
      end
    end
  end

`include "tb_ecc_sram_tasks.svh"

  initial begin : test_sequence
    int unsigned i;
    int unsigned j;
    logic [31:0] val;
    seed        = 58058;
    rst_n_i     = 1'b0;
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    mem_req_i   = '0;
    mem_we_i    = '0;
    mem_addr_i  = '0;
    mem_wdata_i = '0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    // Registers come out of reset cleared, masks all ones
    reg_expect(FieldScrubInterval, 0, 32'h0);
    for (int b = 0; b < NumBanks; b++) begin
      reg_expect(FieldMismatchCount, b, 32'h0);
      reg_expect(FieldScrubFixCount, b, 32'h0);
      reg_expect(FieldMaskDataN, b, 32'hffff_ffff);
      reg_expect(FieldMaskEccN, b, 32'h7f);
    end

    // Clean round trip over both banks, reads back to back
    for (int b = 0; b < NumBanks; b++) begin
      for (int a = 0; a < BankWords; a++) begin
        mem_write(b, a, $random(seed));
      end
    end
    for (int b = 0; b < NumBanks; b++) begin
      for (int a = 0; a < BankWords; a++) begin
        mem_read(b, a, model[b][a], 1'b0, 1'b0);
      end
    end
    wait_reads_done();
    reg_expect(FieldMismatchCount, 0, 32'h0);
    reg_expect(FieldMismatchCount, 1, 32'h0);

    // One flipped data bit in bank 0 is corrected and counted there only
    i = $unsigned($random(seed)) % 32;
    write_masked(0, 3, $random(seed), ~(32'h1 << i), 7'h7f);
    mem_read(0, 3, model[0][3], 1'b1, 1'b0);
    wait_reads_done();
    reg_expect(FieldMismatchCount, 0, 32'h1);
    reg_expect(FieldMismatchCount, 1, 32'h0);

    // One flipped check bit in bank 1, the data itself is intact
    i = $unsigned($random(seed)) % 7;
    write_masked(1, 7, $random(seed), 32'hffff_ffff, ~(7'h1 << i));
    mem_read(1, 7, model[1][7], 1'b1, 1'b0);
    wait_reads_done();
    reg_expect(FieldMismatchCount, 0, 32'h1);
    reg_expect(FieldMismatchCount, 1, 32'h1);

    // Two flipped data bits are flagged and passed through uncorrected
    i   = $unsigned($random(seed)) % 32;
    j   = (i + 1 + $unsigned($random(seed)) % 31) % 32;
    val = (32'h1 << i) | (32'h1 << j);
    write_masked(0, 10, $random(seed), ~val, 7'h7f);
    mem_read(0, 10, model[0][10] ^ val, 1'b0, 1'b1);
    wait_reads_done();
    reg_expect(FieldMismatchCount, 0, 32'h1);

    // Store clean copies so that only the scrub test errors remain in memory
    mem_write(0, 3, model[0][3]);
    mem_write(1, 7, model[1][7]);
    mem_write(0, 10, model[0][10]);

    // Three data flips and one check bit flip in bank 0, then let the scrubber run
    for (int k = 0; k < 3; k++) begin
      i = $unsigned($random(seed)) % 32;
      write_masked(0, 1 + 4 * k, $random(seed), ~(32'h1 << i), 7'h7f);
    end
    i = $unsigned($random(seed)) % 7;
    write_masked(0, 14, $random(seed), 32'hffff_ffff, ~(7'h1 << i));
    reg_write(FieldScrubInterval, 0, 32'd3);
    wait_scrub_count(0, 32'd4);
    // Several more passes over the bank must find nothing left to repair
    repeat (150) @(posedge clk_i);
    #2;
    reg_expect(FieldScrubFixCount, 0, 32'd4);
    reg_expect(FieldScrubFixCount, 1, 32'd0);
    for (int k = 0; k < 3; k++) begin
      mem_read(0, 1 + 4 * k, model[0][1 + 4 * k], 1'b0, 1'b0);
    end
    mem_read(0, 14, model[0][14], 1'b0, 1'b0);
    wait_reads_done();

    // With the interval at zero stored errors stay untouched
    reg_write(FieldScrubInterval, 0, 32'd0);
    repeat (10) @(posedge clk_i);
    #2;
    i = $unsigned($random(seed)) % 32;
    write_masked(0, 6, $random(seed), ~(32'h1 << i), 7'h7f);
    write_masked(1, 2, $random(seed), ~(32'h1 << i), 7'h7f);
    repeat (300) @(posedge clk_i);
    #2;
    reg_expect(FieldScrubFixCount, 0, 32'd4);
    reg_expect(FieldScrubFixCount, 1, 32'd0);

    // Register write and read back
    val = $random(seed);
    reg_write(FieldMismatchCount, 1, val);
    reg_expect(FieldMismatchCount, 1, val);
    val = $random(seed);
    reg_write(FieldScrubFixCount, 0, val);
    reg_expect(FieldScrubFixCount, 0, val);
    val = $random(seed);
    reg_write(FieldMaskDataN, 1, val);
    reg_expect(FieldMaskDataN, 1, val);
    val = $random(seed);
    reg_write(FieldMaskEccN, 0, val);
    // Only the 7 check bits of the mask are stored
    reg_expect(FieldMaskEccN, 0, val & 32'h7f);
    reg_write(FieldMaskDataN, 1, 32'hffff_ffff);
    reg_write(FieldMaskEccN, 0, 32'h7f);
    val = $random(seed);
    reg_write(FieldScrubInterval, 0, val);
    reg_expect(FieldScrubInterval, 0, val);
    reg_write(FieldScrubInterval, 0, 32'd0);

    // Unknown fields and out of range banks are rejected
    for (int f = 5; f < 8; f++) begin
      reg_expect_error(f, 0);
    end
    reg_expect_error(FieldMismatchCount, 2);
    reg_expect_error(FieldMaskEccN, 7);
    reg_expect_error(FieldScrubInterval, 1);

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire
